// File: jag_host_pkg.sv
// shared widths, addresses and download index codes
// status bit positions and BIOS checksum patch constants
`default_nettype none

package jag_host_pkg;

	// ==============================
	// bus widths
	// ==============================
	localparam int IOCTL_ADDR_W = 25; // download byte address
	localparam int MEM_ADDR_W   = 29; // 64-bit memory word address
	localparam int CORE_ADDR_W  = 24; // core byte address bus
	localparam int BIOS_ADDR_W  = 17; // 128k BIOS bytes
	localparam int BRAM_ADDR_W  = 10; // 1k backup words

	localparam int SECTORS = 4; // 512-byte sectors per backup transfer

	// ==============================
	// download index codes
	// ==============================
	// only the low 6 bits select the slot, upper bits carry the file type
	localparam logic [5:0] IDX_BIOS_A = 6'd0;
	localparam logic [5:0] IDX_CART   = 6'd1;
	localparam logic [5:0] IDX_BIOS_B = 6'd2;

	// cart image sits at 8M in core space, region byte on top for memory
	localparam logic [CORE_ADDR_W-1:0] CART_BASE  = 24'h80_0000;
	localparam logic [7:0]             MEM_REGION = 8'h30;

	// BEQ on checksum fail turned into BRA
	localparam logic [BIOS_ADDR_W-1:0] PATCH_ADDR = 17'h0136E;
	localparam logic [7:0]             PATCH_BYTE = 8'h60;

	// ==============================
	// status word bits
	// ==============================
	localparam int ST_PATCH    = 2;
	localparam int ST_REGION   = 4;  // 0 ntsc, 1 pal
	localparam int ST_SAVE     = 11;
	localparam int ST_LOAD     = 12;
	localparam int ST_AUTOSAVE = 13;

	typedef logic [7:0]  byte_t; // BIOS byte
	typedef logic [15:0] word_t; // download / backup word

endpackage

`default_nettype wire

// File: dual_port_ram.sv
// true dual-port synchronous memory, read-first on both ports
// payload type set by a type parameter
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
	parameter type word_t = logic [15:0],
	parameter int  addr_w = 10
) (
	input  logic              clk_sys,
	// port a
	input  logic [addr_w-1:0] addr_a,
	input  word_t             din_a,
	input  logic              we_a,
	output word_t             q_a,
	// port b
	input  logic [addr_w-1:0] addr_b,
	input  word_t             din_b,
	input  logic              we_b,
	output word_t             q_b
);

	word_t mem [0:(1 << addr_w) - 1]; // no init, contents come from loaders

	// port a, old data out on a write
	always @(posedge clk_sys) begin
		q_a <= mem[addr_a];
		if (we_a)
			mem[addr_a] <= din_a;
	end

	// port b
	always @(posedge clk_sys) begin
		q_b <= mem[addr_b];
		if (we_b)
			mem[addr_b] <= din_b;
	end

	// the two writers live in different blocks, a same-word collision
	// would leave the cell undefined
	a_no_write_clash: assert property (@(posedge clk_sys)
		!(we_a && we_b && addr_a == addr_b))
		else $error("both ports write word %0h", addr_a);

endmodule

`default_nettype wire

// File: option_regs.sv
// menu option register
// level options out, one-cycle pulses for backup load/save
`timescale 1ns/1ns
`default_nettype none

module option_regs (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [63:0] status,
	output logic        region,
	output logic        patch_en,
	output logic        autosave,
	output logic        menu_load,
	output logic        menu_save
);
	import jag_host_pkg::*;

	logic [63:0] status_r; // sampled status word

	// tracks through reset too, so no false edge once reset drops
	always_ff @(posedge clk_sys) begin
		status_r <= status;
	end

	assign region   = status_r[ST_REGION];
	assign patch_en = status_r[ST_PATCH];
	assign autosave = status_r[ST_AUTOSAVE];

	// edge detect against last sample, pulse lines up with status_r rising
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			menu_load <= 1'b0;
			menu_save <= 1'b0;
		end else begin
			menu_load <= status[ST_LOAD] & ~status_r[ST_LOAD];
			menu_save <= status[ST_SAVE] & ~status_r[ST_SAVE]; // menu button
		end
	end

endmodule

`default_nettype wire

// File: cart_loader.sv
// cart ROM download path
// 16-bit download words to 64-bit memory writes with lane enables
`timescale 1ns/1ns
`default_nettype none

module cart_loader (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               ioctl_download,
	input  logic                               ioctl_wr,
	input  logic [7:0]                         ioctl_index,
	input  jag_host_pkg::word_t                ioctl_data,
	input  logic                               mem_busy,
	output logic                               ioctl_wait,
	output logic                               loading,
	output logic                               mem_we,
	output logic [jag_host_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [7:0]                         mem_be,
	output logic [63:0]                        mem_din
);
	import jag_host_pkg::*;

	logic                   old_download;
	logic [CORE_ADDR_W-1:0] load_addr;  // byte address of current word
	word_t                  data_r;     // word held for the write cycle
	word_t                  data_swap;

	wire cart_idx = ioctl_index[5:0] == IDX_CART;

	// ==============================
	// download window and address
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			loading      <= 1'b0;
			mem_we       <= 1'b0;
			load_addr    <= CART_BASE;
		end else begin
			old_download <= ioctl_download;
			mem_we       <= ioctl_wr & loading; // one cycle behind the host strobe

			if (mem_we)
				load_addr <= load_addr + 24'd2; // one 16-bit word per write

			if (~old_download & ioctl_download & cart_idx) begin
				loading   <= 1'b1;
				load_addr <= CART_BASE;
			end

			if (old_download & ~ioctl_download)
				loading <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr)
			data_r <= ioctl_data;
	end

	// ==============================
	// memory side
	// ==============================
	assign mem_addr = {MEM_REGION, load_addr[23:3]};

	// ROM is big endian, memory lanes are little endian
	assign data_swap = {data_r[7:0], data_r[15:8]};
	assign mem_din   = {4{data_swap}};

	// top lane first within the 64-bit line
	always_comb begin
		if (!loading) begin
			mem_be = 8'hFF; // reads want all lanes
		end else begin
			case (load_addr[2:1])
				2'd0:    mem_be = 8'hC0;
				2'd1:    mem_be = 8'h30;
				2'd2:    mem_be = 8'h0C;
				default: mem_be = 8'h03;
			endcase
		end
	end

	assign ioctl_wait = loading & mem_busy; // host holds wr while high

	a_one_lane: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> $countones(mem_be) == 2)
		else $error("cart write enables %0h not a single word lane", mem_be);

endmodule

`default_nettype wire

// File: bios_loader.sv
// BIOS download byte splitter and on-chip BIOS memory
// read side patches the cart checksum branch
`timescale 1ns/1ns
`default_nettype none

module bios_loader (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download,
	input  logic                                 ioctl_wr,
	input  logic [7:0]                           ioctl_index,
	input  logic [jag_host_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  jag_host_pkg::word_t                  ioctl_data,
	input  logic                                 patch_en,
	input  logic [jag_host_pkg::BIOS_ADDR_W-1:0]  bios_addr,
	output jag_host_pkg::byte_t                  bios_q
);
	import jag_host_pkg::*;

	logic                   wr_en;      // byte write this cycle
	logic                   lsb;        // 0 while low byte goes in
	logic [BIOS_ADDR_W-2:0] word_addr;
	byte_t                  wr_byte;
	byte_t                  hi_byte;    // waits one cycle
	byte_t                  rd_byte;
	logic                   patch_hit;

	wire bios_dl = ioctl_download &
		(ioctl_index[5:0] == IDX_BIOS_A || ioctl_index[5:0] == IDX_BIOS_B);

	// word in, low byte next cycle, high byte the one after
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_en <= 1'b0;
			lsb   <= 1'b1;
		end else if (bios_dl && ioctl_wr) begin
			wr_en <= 1'b1;
			lsb   <= 1'b0;
		end else if (!lsb) begin
			wr_en <= 1'b1;
			lsb   <= 1'b1; // high byte phase
		end else begin
			wr_en <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bios_dl && ioctl_wr) begin
			word_addr <= ioctl_addr[BIOS_ADDR_W-1:1];
			wr_byte   <= ioctl_data[7:0];
			hi_byte   <= ioctl_data[15:8];
		end else if (!lsb) begin
			wr_byte <= hi_byte;
		end
		patch_hit <= bios_addr == PATCH_ADDR; // matches the read latency
	end

	dual_port_ram #(.word_t(byte_t), .addr_w(BIOS_ADDR_W)) u_bios_ram (
		.clk_sys (clk_sys),
		.addr_a  ({word_addr, lsb}),
		.din_a   (wr_byte),
		.we_a    (wr_en),
		.q_a     (),
		.addr_b  (bios_addr),
		.din_b   (8'h00),
		.we_b    (1'b0),
		.q_b     (rd_byte)
	);

	assign bios_q = (patch_en && patch_hit) ? PATCH_BYTE : rd_byte; // beq -> bra

	// a word right behind another would drop the pending high byte
	a_wr_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		!lsb |-> !(bios_dl && ioctl_wr))
		else $error("BIOS write during high byte cycle");

endmodule

`default_nettype wire

// File: backup_sequencer.sv
// backup RAM and its SD sector sequencer
// enable/pending flags, idle/busy machine, four sectors per transfer
`timescale 1ns/1ns
`default_nettype none

module backup_sequencer (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_download,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic                                 osd_open,
	input  logic                                 menu_load,
	input  logic                                 menu_save,
	input  logic                                 autosave,
	input  logic [jag_host_pkg::BRAM_ADDR_W-1:0]  bram_addr,
	input  jag_host_pkg::word_t                  bram_data,
	input  logic                                 bram_wr,
	output jag_host_pkg::word_t                  bram_q,
	input  logic                                 sd_ack,
	input  logic [7:0]                           sd_buff_addr,
	input  jag_host_pkg::word_t                  sd_buff_dout,
	input  logic                                 sd_buff_wr,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	output logic [31:0]                          sd_lba,
	output jag_host_pkg::word_t                  sd_buff_din,
	output logic                                 busy,
	output logic                                 pending
);
	import jag_host_pkg::*;

	typedef enum logic {S_IDLE, S_BUSY} state_t;

	state_t state;
	logic   bk_ena;     // writable save image present
	logic   is_load;    // direction of the running transfer
	logic   old_dl;
	logic   old_ack;
	logic   old_auto;

	wire auto_req  = pending & osd_open & autosave;
	wire auto_rise = auto_req & ~old_auto;
	wire dl_end    = old_dl & ~cart_download;
	wire last_sec  = sd_lba[1:0] == 2'(SECTORS - 1);

	assign busy = state == S_BUSY;

	// ==============================
	// enable and pending flags
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (~old_dl & cart_download)
				bk_ena <= 1'b0; // new cart, old save is stale
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1; // save file is mounted during the download

			if (bk_ena && !osd_open && bram_wr)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// ==============================
	// sector sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= S_IDLE;
			is_load  <= 1'b0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			sd_lba   <= 32'd0;
			old_dl   <= 1'b0;
			old_ack  <= 1'b0;
			old_auto <= 1'b0;
		end else begin
			old_dl   <= cart_download;
			old_ack  <= sd_ack;
			old_auto <= auto_req;

			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0; // host took the request
				sd_wr <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (bk_ena && (menu_load || menu_save || auto_rise || dl_end)) begin
						state   <= S_BUSY;
						is_load <= menu_load | dl_end;
						sd_lba  <= 32'd0;
						sd_rd   <= menu_load | dl_end;
						sd_wr   <= ~(menu_load | dl_end);
					end
				end
				S_BUSY: begin
					if (old_ack & ~sd_ack) begin // sector done
						if (last_sec) begin
							state  <= S_IDLE;
							sd_lba <= 32'd0;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= is_load;
							sd_wr  <= ~is_load;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	dual_port_ram #(.word_t(word_t), .addr_w(BRAM_ADDR_W)) u_backup_ram (
		.clk_sys (clk_sys),
		.addr_a  (bram_addr), // core side
		.din_a   (bram_data),
		.we_a    (bram_wr),
		.q_a     (bram_q),
		.addr_b  ({sd_lba[1:0], sd_buff_addr}),
		.din_b   (sd_buff_dout),
		.we_b    (sd_buff_wr & sd_ack),
		.q_b     (sd_buff_din)
	);

	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> busy && !(sd_rd && sd_wr))
		else $error("SD request outside a transfer or in both directions");

endmodule

`default_nettype wire

// File: jag_host_io.sv
// host-side glue top: option register, cart and BIOS loaders,
// backup sequencer, user LED
`timescale 1ns/1ns
`default_nettype none

module jag_host_io (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [63:0]                          status,
	// download
	input  logic                                 ioctl_download,
	input  logic                                 ioctl_wr,
	input  logic [7:0]                           ioctl_index,
	input  logic [jag_host_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  jag_host_pkg::word_t                  ioctl_data,
	output logic                                 ioctl_wait,
	// cart memory
	input  logic                                 mem_busy,
	output logic                                 mem_we,
	output logic [jag_host_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic [7:0]                           mem_be,
	output logic [63:0]                          mem_din,
	// BIOS read
	input  logic [jag_host_pkg::BIOS_ADDR_W-1:0]  bios_addr,
	output jag_host_pkg::byte_t                  bios_q,
	// backup RAM, core side
	input  logic [jag_host_pkg::BRAM_ADDR_W-1:0]  bram_addr,
	input  jag_host_pkg::word_t                  bram_data,
	input  logic                                 bram_wr,
	output jag_host_pkg::word_t                  bram_q,
	// SD image
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic                                 sd_ack,
	input  logic [7:0]                           sd_buff_addr,
	input  jag_host_pkg::word_t                  sd_buff_dout,
	input  logic                                 sd_buff_wr,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	output logic [31:0]                          sd_lba,
	output jag_host_pkg::word_t                  sd_buff_din,
	input  logic                                 osd_open,
	output logic                                 region,
	output logic                                 led_user
);

	logic patch_en;
	logic autosave;
	logic menu_load;
	logic menu_save;
	logic loading;  // cart download window
	logic busy;
	logic pending;

	option_regs u_option_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.status    (status),
		.region    (region),
		.patch_en  (patch_en),
		.autosave  (autosave),
		.menu_load (menu_load),
		.menu_save (menu_save)
	);

	cart_loader u_cart_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_data     (ioctl_data),
		.mem_busy       (mem_busy),
		.ioctl_wait     (ioctl_wait),
		.loading        (loading),
		.mem_we         (mem_we),
		.mem_addr       (mem_addr),
		.mem_be         (mem_be),
		.mem_din        (mem_din)
	);

	bios_loader u_bios_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.patch_en       (patch_en),
		.bios_addr      (bios_addr),
		.bios_q         (bios_q)
	);

	// cart window drives backup enable and the load after download
	backup_sequencer u_backup_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (loading),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.osd_open      (osd_open),
		.menu_load     (menu_load),
		.menu_save     (menu_save),
		.autosave      (autosave),
		.bram_addr     (bram_addr),
		.bram_data     (bram_data),
		.bram_wr       (bram_wr),
		.bram_q        (bram_q),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_lba        (sd_lba),
		.sd_buff_din   (sd_buff_din),
		.busy          (busy),
		.pending       (pending)
	);

	assign led_user = ioctl_download | busy | pending; // any host activity

endmodule

`default_nettype wire

// File: tb_jag_host_io.sv
// testbench for the host-side glue top
// SD host model, reference memories, concurrent checks, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_jag_host_io;
	import jag_host_pkg::*;

	localparam int CLK_NS     = 4;
	localparam int RESET_CYC  = 8;
	localparam int BIOS_WORDS = 32;
	localparam int CART_WORDS = 64;
	localparam int BIOS_CYC   = BIOS_WORDS * 2 + 4 * BIOS_WORDS + 40;
	localparam int CART_CYC   = CART_WORDS * 12 + 40;
	localparam int XFER_CYC   = SECTORS * (256 + 16) + 20; // gap, ack, stream, drop
	localparam int CORE_CYC   = 3 * 1024 + 64;
	localparam int TOTAL_CYC  = RESET_CYC + BIOS_CYC + CART_CYC + 4 * XFER_CYC + CORE_CYC;
	localparam logic [BIOS_ADDR_W-1:0] BIOS_BASE = PATCH_ADDR - 17'h1E; // window around patch

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic [63:0]             status;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [7:0]              ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	word_t                   ioctl_data;
	logic                    ioctl_wait;
	logic                    mem_busy;
	logic                    mem_we;
	logic [MEM_ADDR_W-1:0]   mem_addr;
	logic [7:0]              mem_be;
	logic [63:0]             mem_din;
	logic [BIOS_ADDR_W-1:0]  bios_addr;
	byte_t                   bios_q;
	logic [BRAM_ADDR_W-1:0]  bram_addr;
	word_t                   bram_data;
	logic                    bram_wr;
	word_t                   bram_q;
	logic                    img_mounted;
	logic                    img_readonly;
	logic                    sd_ack;
	logic [7:0]              sd_buff_addr;
	word_t                   sd_buff_dout;
	logic                    sd_buff_wr;
	logic                    sd_rd;
	logic                    sd_wr;
	logic [31:0]             sd_lba;
	word_t                   sd_buff_din;
	logic                    osd_open;
	logic                    region;
	logic                    led_user;

	int    errors = 0;
	byte_t bios_ref [0:2*BIOS_WORDS-1]; // bytes of the BIOS window
	word_t bram_ref [0:(1 << BRAM_ADDR_W)-1];
	// stimulus flags
	logic  cart_window;
	logic  bios_rd;
	logic  core_rd;
	logic  bk_on;
	logic  exp_save;
	// host model flags
	logic  save_rd;
	logic  xfer_end;
	logic [1:0] host_sector;   // expected lba

	// one cycle delayed expectations
	logic                    cart_wr_q;
	logic [IOCTL_ADDR_W-1:0] cart_addr_q;
	word_t                   cart_data_q;
	logic                    bios_rd_q;
	byte_t                   bios_exp_q;
	logic                    core_rd_q;
	word_t                   core_exp_q;
	logic                    save_rd_q;
	word_t                   save_exp_q;

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	jag_host_io u_jag_host_io (
		.clk_sys(clk_sys), .reset(reset), .status(status),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wait(ioctl_wait),
		.mem_busy(mem_busy), .mem_we(mem_we), .mem_addr(mem_addr), .mem_be(mem_be),
		.mem_din(mem_din), .bios_addr(bios_addr), .bios_q(bios_q),
		.bram_addr(bram_addr), .bram_data(bram_data), .bram_wr(bram_wr), .bram_q(bram_q),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba), .sd_buff_din(sd_buff_din),
		.osd_open(osd_open), .region(region), .led_user(led_user)
	);

	// ==============================
	// expected values
	// ==============================
	function automatic logic [MEM_ADDR_W-1:0] cart_mem_addr(input logic [IOCTL_ADDR_W-1:0] ofs);
		logic [CORE_ADDR_W-1:0] a;
		a = CART_BASE + ofs[CORE_ADDR_W-1:0];
		cart_mem_addr = {MEM_REGION, a[23:3]};
	endfunction

	function automatic logic [7:0] lane_enables(input logic [IOCTL_ADDR_W-1:0] ofs);
		logic [CORE_ADDR_W-1:0] a;
		a = CART_BASE + ofs[CORE_ADDR_W-1:0];
		case (a[2:1])
			2'd0:    lane_enables = 8'hC0; // top lane first
			2'd1:    lane_enables = 8'h30;
			2'd2:    lane_enables = 8'h0C;
			default: lane_enables = 8'h03;
		endcase
	endfunction

	function automatic logic [63:0] swapped_line(input word_t d);
		swapped_line = {4{d[7:0], d[15:8]}};
	endfunction

	// backup memory model plus read latency stage
	always @(posedge clk_sys) begin
		cart_wr_q   <= ioctl_wr & cart_window;
		cart_addr_q <= ioctl_addr;
		cart_data_q <= ioctl_data;
		bios_rd_q   <= bios_rd;
		if (status[ST_PATCH] && bios_addr == PATCH_ADDR)
			bios_exp_q <= PATCH_BYTE;
		else
			bios_exp_q <= bios_ref[6'(bios_addr - BIOS_BASE)];
		core_rd_q  <= core_rd;
		core_exp_q <= bram_ref[bram_addr]; // read-first returns old data
		save_rd_q  <= save_rd;
		save_exp_q <= bram_ref[{host_sector, sd_buff_addr}];
		if (bram_wr)
			bram_ref[bram_addr] <= bram_data;
		if (sd_ack && sd_buff_wr)
			bram_ref[{host_sector, sd_buff_addr}] <= sd_buff_dout;
	end

	task automatic flag_mismatch(input string msg);
		errors = errors + 1;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	// ==============================
	// checks
	// ==============================
	a_reset_idle: assert property (@(posedge clk_sys) $fell(reset) |->
		!mem_we && !sd_rd && !sd_wr && !led_user && !ioctl_wait)
		else flag_mismatch("outputs not idle after reset");
	a_cart_write: assert property (@(posedge clk_sys) disable iff (reset) cart_wr_q |->
		mem_we && mem_addr == cart_mem_addr(cart_addr_q) &&
		mem_be == lane_enables(cart_addr_q) && mem_din == swapped_line(cart_data_q))
		else flag_mismatch($sformatf("cart write for offset %0h wrong", cart_addr_q));
	a_cart_only: assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> cart_wr_q)
		else flag_mismatch("mem_we without a cart download write");
	a_wait_follow: assert property (@(posedge clk_sys) disable iff (reset)
		cart_window |-> ioctl_wait == mem_busy)
		else flag_mismatch("ioctl_wait does not follow mem_busy");
	a_idle_bus: assert property (@(posedge clk_sys) disable iff (reset)
		!ioctl_download && !$past(ioctl_download) |-> !ioctl_wait && mem_be == 8'hFF)
		else flag_mismatch("wait or lane enables active outside a download");
	a_region_level: assert property (@(posedge clk_sys) disable iff (reset)
		region == $past(status[ST_REGION]))
		else flag_mismatch("region does not follow its status bit");
	a_bios_read: assert property (@(posedge clk_sys) disable iff (reset)
		bios_rd_q |-> bios_q == bios_exp_q)
		else flag_mismatch($sformatf("bios_q %0h, expected %0h", bios_q, bios_exp_q));
	a_core_read: assert property (@(posedge clk_sys) disable iff (reset)
		core_rd_q |-> bram_q == core_exp_q)
		else flag_mismatch($sformatf("bram_q %0h, expected %0h", bram_q, core_exp_q));
	a_save_data: assert property (@(posedge clk_sys) disable iff (reset)
		save_rd_q |-> sd_buff_din == save_exp_q)
		else flag_mismatch($sformatf("sd_buff_din %0h, expected %0h", sd_buff_din, save_exp_q));
	a_sector_order: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> sd_lba == {30'd0, host_sector})
		else flag_mismatch($sformatf("request for lba %0d, expected %0d", sd_lba, host_sector));
	a_direction: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> sd_wr == exp_save && sd_rd == !exp_save)
		else flag_mismatch("SD request in the wrong direction");
	a_pending_led: assert property (@(posedge clk_sys) disable iff (reset)
		bram_wr && !osd_open && bk_on |=> led_user)
		else flag_mismatch("core write did not light led_user");
	a_xfer_end: assert property (@(posedge clk_sys) disable iff (reset)
		xfer_end |-> !sd_rd && !sd_wr && sd_lba == 32'd0 && !led_user)
		else flag_mismatch("sequencer not idle after the last sector");

	// ==============================
	// SD host model
	// ==============================
	initial begin : sd_host
		int   gap;
		logic save_dir;
		sd_ack       = 1'b0;
		sd_buff_addr = 8'd0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		save_rd      = 1'b0;
		xfer_end     = 1'b0;
		host_sector  = 2'd0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!reset && (sd_rd || sd_wr)) begin
				save_dir = sd_wr;
				gap = 1 + $urandom % 4; // host latency
				repeat (gap) @(posedge clk_sys);
				#1;
				sd_ack = 1'b1;
				for (int i = 0; i < 256; i++) begin
					@(posedge clk_sys);
					#1;
					sd_buff_addr = 8'(i);
					if (save_dir) begin
						save_rd = 1'b1;
					end else begin
						sd_buff_dout = word_t'($urandom);
						sd_buff_wr   = 1'b1;
					end
				end
				@(posedge clk_sys);
				#1;
				sd_buff_wr = 1'b0;
				save_rd    = 1'b0;
				@(posedge clk_sys);
				#1;
				sd_ack      = 1'b0;
				host_sector = host_sector + 2'd1; // wraps after sector 3
				if (host_sector == 2'd0) begin
					@(posedge clk_sys);
					#1;
					xfer_end = 1'b1;
					@(posedge clk_sys);
					#1;
					xfer_end = 1'b0;
				end
			end
		end
	end

	// ==============================
	// stimulus
	// ==============================
	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic bios_write_word(input logic [IOCTL_ADDR_W-1:0] a, input word_t d);
		logic [5:0] ofs;
		ofs = 6'(a - BIOS_BASE);
		bios_ref[ofs]     = d[7:0];  // low byte at even address
		bios_ref[ofs + 1] = d[15:8];
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr   = 1'b1;
		idle_cycles(1);
		ioctl_wr = 1'b0;
		idle_cycles(1); // high byte cycle
	endtask

	task automatic bios_read_pass();
		bios_rd = 1'b1;
		for (int i = 0; i < 2 * BIOS_WORDS; i++) begin
			bios_addr = BIOS_BASE + BIOS_ADDR_W'(i);
			idle_cycles(1);
		end
		bios_rd = 1'b0;
		idle_cycles(2);
	endtask

	task automatic cart_write_word(input logic [IOCTL_ADDR_W-1:0] ofs, input word_t d);
		mem_busy = ($urandom % 4) == 0;
		while (mem_busy) begin // host holds off while waited
			idle_cycles(1);
			mem_busy = ($urandom % 4) == 0;
		end
		ioctl_addr = ofs;
		ioctl_data = d;
		ioctl_wr   = 1'b1;
		idle_cycles(1);
		ioctl_wr = 1'b0;
		idle_cycles(1);
	endtask

	task automatic core_write(input logic [BRAM_ADDR_W-1:0] a, input word_t d);
		bram_addr = a;
		bram_data = d;
		bram_wr   = 1'b1;
		idle_cycles(1);
		bram_wr = 1'b0;
	endtask

	task automatic core_read_sweep();
		core_rd = 1'b1;
		for (int i = 0; i < (1 << BRAM_ADDR_W); i++) begin
			bram_addr = BRAM_ADDR_W'(i);
			idle_cycles(1);
		end
		core_rd = 1'b0;
		idle_cycles(2);
	endtask

	task automatic pulse_status(input int bit_pos);
		status[bit_pos] = 1'b1;
		idle_cycles(2);
		status[bit_pos] = 1'b0;
	endtask

	// request seen, then LED off marks busy falling
	task automatic wait_transfer_done();
		while (!(sd_rd || sd_wr))
			idle_cycles(1);
		while (led_user)
			idle_cycles(1);
		idle_cycles(3);
	endtask

	initial begin : stimulus
		word_t                   d;
		logic [IOCTL_ADDR_W-1:0] a;
		void'($urandom(32'h4793be50));
		reset          = 1'b1;
		status         = '0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'hFF;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		mem_busy       = 1'b0;
		bios_addr      = '0;
		bram_addr      = '0;
		bram_data      = '0;
		bram_wr        = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		osd_open       = 1'b0;
		cart_window    = 1'b0;
		bios_rd        = 1'b0;
		core_rd        = 1'b0;
		bk_on          = 1'b0;
		exp_save       = 1'b0;
		idle_cycles(RESET_CYC);
		reset = 1'b0;
		idle_cycles(2);

		// BIOS window, then reads with patch off and on
		ioctl_index    = {2'b00, IDX_BIOS_A};
		ioctl_download = 1'b1;
		idle_cycles(1);
		for (int i = 0; i < BIOS_WORDS; i++) begin
			a = IOCTL_ADDR_W'(BIOS_BASE) + IOCTL_ADDR_W'(2 * i);
			d = word_t'($urandom);
			if (a == PATCH_ADDR && d[7:0] == PATCH_BYTE)
				d[7:0] = ~PATCH_BYTE; // patch must be visible
			bios_write_word(a, d);
		end
		ioctl_download = 1'b0;
		idle_cycles(2);
		bios_read_pass();
		status[ST_PATCH]  = 1'b1;
		status[ST_REGION] = 1'b1; // pal from here on
		idle_cycles(3);
		bios_read_pass();

		// cart download with writable image, load follows
		img_mounted    = 1'b1;
		ioctl_index    = {2'b00, IDX_CART};
		ioctl_download = 1'b1;
		idle_cycles(2);
		cart_window = 1'b1;
		for (int i = 0; i < CART_WORDS; i++)
			cart_write_word(IOCTL_ADDR_W'(2 * i), word_t'($urandom));
		cart_window = 1'b0;
		idle_cycles(1);
		ioctl_download = 1'b0;
		bk_on          = 1'b1;
		wait_transfer_done();
		core_read_sweep();

		// menu save of core data
		for (int i = 0; i < (1 << BRAM_ADDR_W); i++)
			core_write(BRAM_ADDR_W'(i), word_t'($urandom));
		exp_save = 1'b1;
		pulse_status(ST_SAVE);
		wait_transfer_done();

		// menu load
		exp_save = 1'b0;
		pulse_status(ST_LOAD);
		wait_transfer_done();
		core_read_sweep();

		// pending write, then menu open with autosave
		status[ST_AUTOSAVE] = 1'b1;
		idle_cycles(2);
		for (int i = 0; i < 16; i++)
			core_write(BRAM_ADDR_W'($urandom), word_t'($urandom));
		exp_save = 1'b1;
		osd_open = 1'b1;
		wait_transfer_done();
		osd_open = 1'b0;
		idle_cycles(4);

		$display("checks complete, error count %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin : watchdog
		#(TOTAL_CYC * 2 * CLK_NS);
		$display("watchdog expired before the test sequence finished");
		$display("checks complete, error count %0d", errors);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: jag_host_io.f
jag_host_pkg.sv
dual_port_ram.sv
option_regs.sv
cart_loader.sv
bios_loader.sv
backup_sequencer.sv
jag_host_io.sv
tb_jag_host_io.sv

// File: Bender.yml
package:
  name: jag_host_io

sources:
  - files:
      - jag_host_pkg.sv
      - dual_port_ram.sv
      - option_regs.sv
      - cart_loader.sv
      - bios_loader.sv
      - backup_sequencer.sv
      - jag_host_io.sv
  - target: test
    files:
      - tb_jag_host_io.sv
